// File: cp0.f
cp0_pkg.sv
cp0_access.sv
cp0_status.sv
cp0_exception_regs.sv
cp0_timer.sv
cp0.sv
cp0_checker.sv
tb_cp0.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal
TOP       := tb_cp0
FILELIST  := cp0.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -qx "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_cp0.sv
`timescale 1ns/100ps

module tb_cp0;

    import cp0_pkg::*;

    localparam int          period       = 40;
    localparam int          drive_delay  = 5; // After the rising edge
    localparam int          reset_cycles = 8;
    localparam logic [31:0] compare_init = 32'h0001_55cc;

    localparam logic [2:0] op_idle    = 3'd0;
    localparam logic [2:0] op_mtc0    = 3'd1;
    localparam logic [2:0] op_mfc0    = 3'd2;
    localparam logic [2:0] op_exc     = 3'd3;
    localparam logic [2:0] op_eret    = 3'd4;
    localparam logic [2:0] op_mtc0_ex = 3'd5; // mtc0 that faults itself
    localparam logic [2:0] op_eret_ex = 3'd6;

    typedef struct packed {
        logic [2:0]  op;
        cp0_addr_t   addr;
        logic [31:0] data;
        exc_type_t   exc;
        logic        bd;
        logic [31:0] pc;
        logic [5:0]  ext;
        logic        check; // Table value below is meaningful
        logic [31:0] expected;
    } row_t;

    row_t rows[$];
    bit   table_ready;

    logic              clk;
    logic              reset;
    logic              m1s_valid;
    logic              m1s_inst_mtc0;
    logic              m1s_inst_eret;
    logic              m1s_bd;
    logic              m1s_ex;
    logic [4:0]        m1s_rd;
    logic [2:0]        m1s_sel;
    logic [data_w-1:0] m1s_alu_result;
    logic [data_w-1:0] m1s_pc;
    exc_type_t         exc_type;
    logic [5:0]        ext_int;
    logic [data_w-1:0] cp0_data;
    logic              eret_flush;
    logic [data_w-1:0] epc_out;
    logic              status_ie;
    logic              status_exl;
    logic [7:0]        status_im;
    logic [7:0]        cause_ip;
    logic              cause_ti;
    logic              read_check;
    logic              exp_valid;
    logic [data_w-1:0] exp_data;
    logic              exp_flush;
    int                model_errors;
    int                table_errors;

    cp0 #(.compare_reset(compare_init)) i_dut (.*);

    cp0_checker #(.compare_reset(compare_init)) i_checker (.*);

    task automatic add_row(input logic [2:0] op, input cp0_addr_t addr, input logic [31:0] data,
                           input exc_type_t exc, input logic bd, input logic [31:0] pc,
                           input logic [5:0] ext, input logic check, input logic [31:0] expected);
        rows.push_back(row_t'{op, addr, data, exc, bd, pc, ext, check, expected});
    endtask

    task automatic write_reg(input cp0_addr_t addr, input logic [31:0] data);
        add_row(op_mtc0, addr, data, exc_none, 1'b0, '0, '0, 1'b0, '0);
    endtask

    task automatic read_reg(input cp0_addr_t addr, input logic check, input logic [31:0] expected);
        add_row(op_mfc0, addr, '0, exc_none, 1'b0, '0, '0, check, expected);
    endtask

    task automatic raise_exception(input exc_type_t exc, input logic [31:0] pc,
                                   input logic [31:0] alu, input logic bd);
        add_row(op_exc, '0, alu, exc, bd, pc, '0, 1'b0, '0);
    endtask

    task automatic return_from_exception();
        add_row(op_eret, '0, '0, exc_none, 1'b0, '0, '0, 1'b0, '0);
    endtask

    task automatic hold_interrupts(input logic [5:0] ext);
        add_row(op_idle, '0, '0, exc_none, 1'b0, '0, ext, 1'b0, '0);
    endtask

    task automatic idle_cycles(input int n);
        logic [31:0] rnd;
        int          i;
        for (i = 0; i < n; i++) begin
            rnd = $urandom;
            hold_interrupts(rnd[5:0]);
        end
    endtask

    // Row i lands on edge i+2 after reset
    // Count steps on even edges
    function automatic logic [31:0] count_at(input int w, input int r, input logic [31:0] value);
        return value + 32'((r + 1) / 2 - (w + 2) / 2);
    endfunction

    task automatic build_table();
        logic [31:0] rnd;
        int          w;
        write_reg(addr_status, 32'hffff_ffff);
        read_reg(addr_status, 1'b1, 32'h1040_ff17);
        write_reg(addr_status, 32'h0000_ff01);
        read_reg(addr_status, 1'b1, 32'h0000_ff01);
        add_row(op_mtc0_ex, addr_status, '0, exc_ov, 1'b0, 32'hbfc0_0100, '0, 1'b0, '0);
        read_reg(addr_status, 1'b1, 32'h0000_ff03);
        return_from_exception();
        read_reg(addr_status, 1'b1, 32'h0000_ff01);
        rnd = $urandom;
        write_reg(addr_epc, rnd);
        read_reg(addr_epc, 1'b1, rnd);
        read_reg(addr_compare, 1'b1, compare_init);
        read_reg({5'd3, 3'd0}, 1'b1, '0);
        read_reg({5'd12, 3'd1}, 1'b1, '0);
        raise_exception(exc_sys, 32'h0040_0010, '0, 1'b0);
        read_reg(addr_epc, 1'b1, 32'h0040_0010);
        read_reg(addr_cause, 1'b1, 32'h0000_0020);
        return_from_exception();
        raise_exception(exc_bp, 32'h0040_0020, '0, 1'b1);
        read_reg(addr_epc, 1'b1, 32'h0040_001c);
        read_reg(addr_cause, 1'b1, 32'h8000_0024);
        raise_exception(exc_ri, 32'h0040_0100, '0, 1'b0); // Nested so EPC and BD hold
        read_reg(addr_epc, 1'b1, 32'h0040_001c);
        read_reg(addr_cause, 1'b1, 32'h8000_0028);
        return_from_exception();
        raise_exception(exc_cpu, 32'h0040_0200, '0, 1'b0);
        read_reg(addr_cause, 1'b1, 32'h1000_002c);
        return_from_exception();
        raise_exception(exc_int, 32'h0040_0210, '0, 1'b0);
        read_reg(addr_cause, 1'b1, 32'h1000_0000);
        return_from_exception();
        raise_exception(exc_ov, 32'h0040_0220, '0, 1'b0);
        read_reg(addr_cause, 1'b1, 32'h1000_0030);
        return_from_exception();
        raise_exception(exc_trap, 32'h0040_0230, '0, 1'b0);
        read_reg(addr_cause, 1'b1, 32'h1000_0034);
        return_from_exception();
        add_row(op_eret_ex, '0, '0, exc_sys, 1'b0, 32'h0040_0600, '0, 1'b0, '0);
        read_reg(addr_status, 1'b1, 32'h0000_ff03);
        return_from_exception();
        read_reg(addr_status, 1'b1, 32'h0000_ff01);
        raise_exception(exc_ades, 32'h0040_0300, 32'h1000_0003, 1'b0);
        read_reg(addr_badvaddr, 1'b1, 32'h1000_0003);
        read_reg(addr_cause, 1'b1, 32'h1000_0014);
        return_from_exception();
        raise_exception(exc_adel, 32'h0040_0402, 32'h2000_0000, 1'b0);
        read_reg(addr_badvaddr, 1'b1, 32'h0040_0402);
        read_reg(addr_cause, 1'b1, 32'h1000_0010);
        return_from_exception();
        raise_exception(exc_adel, 32'h0040_0500, 32'h2000_0001, 1'b0);
        read_reg(addr_badvaddr, 1'b1, 32'h2000_0001);
        return_from_exception();
        w = rows.size();
        write_reg(addr_count, 32'h0000_0100);
        write_reg(addr_compare, 32'h0000_0104);
        idle_cycles(12);
        read_reg(addr_count, 1'b1, count_at(w, rows.size(), 32'h0000_0100));
        read_reg(addr_cause, 1'b1, 32'h5000_8010); // TI and IP7 up
        write_reg(addr_compare, 32'hffff_0000);
        read_reg(addr_cause, 1'b1, 32'h1000_8010); // IP7 trails TI by one edge
        read_reg(addr_cause, 1'b1, 32'h1000_0010);
        read_reg(addr_compare, 1'b1, 32'hffff_0000);
        write_reg(addr_cause, 32'h0000_0300);
        read_reg(addr_cause, 1'b1, 32'h1000_0310);
        hold_interrupts(6'h2a);
        read_reg(addr_cause, 1'b1, 32'h1000_ab10);
        idle_cycles(16);
        read_reg(addr_cause, 1'b0, '0);
    endtask

    task automatic apply_row(input row_t r);
        m1s_valid      = (r.op != op_idle);
        m1s_inst_mtc0  = (r.op == op_mtc0) || (r.op == op_mtc0_ex);
        m1s_inst_eret  = (r.op == op_eret) || (r.op == op_eret_ex);
        m1s_ex         = (r.op == op_exc) || (r.op == op_mtc0_ex) || (r.op == op_eret_ex);
        m1s_bd         = r.bd;
        m1s_rd         = r.addr[7:3];
        m1s_sel        = r.addr[2:0];
        m1s_alu_result = r.data;
        m1s_pc         = r.pc;
        exc_type       = r.exc;
        ext_int        = r.ext;
        read_check     = (r.op == op_mfc0);
        exp_valid      = r.check;
        exp_data       = r.expected;
        exp_flush      = (r.op == op_eret); // Only an eret that does not fault
    endtask

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        wait (table_ready);
        #((rows.size() + 20) * period);
        $display("Timeout: the stimulus table did not complete within %0d cycles",
                 rows.size() + 20);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h8c96_d0e0));
        reset = 1'b1;
        apply_row(row_t'{op_idle, 8'h00, 32'h0, exc_none, 1'b0, 32'h0, 6'h0, 1'b0, 32'h0});
        build_table();
        table_ready = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #(drive_delay);
        reset = 1'b0;
        foreach (rows[i]) begin
            @(posedge clk);
            #(drive_delay);
            apply_row(rows[i]);
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        $display("Checks done: %0d model mismatches, %0d table mismatches",
                 model_errors, table_errors);
        if (model_errors == 0 && table_errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// File: cp0_checker.sv
`timescale 1ns/100ps

module cp0_checker #(
    parameter logic [cp0_pkg::data_w-1:0] compare_reset = 32'h0001_55cc
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       m1s_valid,
    input  logic                       m1s_inst_mtc0,
    input  logic                       m1s_inst_eret,
    input  logic                       m1s_bd,
    input  logic                       m1s_ex,
    input  logic [4:0]                 m1s_rd,
    input  logic [2:0]                 m1s_sel,
    input  logic [cp0_pkg::data_w-1:0] m1s_alu_result,
    input  logic [cp0_pkg::data_w-1:0] m1s_pc,
    input  cp0_pkg::exc_type_t         exc_type,
    input  logic [5:0]                 ext_int,
    input  logic [cp0_pkg::data_w-1:0] cp0_data,
    input  logic                       eret_flush,
    input  logic [cp0_pkg::data_w-1:0] epc_out,
    input  logic                       status_ie,
    input  logic                       status_exl,
    input  logic [7:0]                 status_im,
    input  logic [7:0]                 cause_ip,
    input  logic                       cause_ti,
    input  logic                       read_check,
    input  logic                       exp_valid,
    input  logic [cp0_pkg::data_w-1:0] exp_data,
    input  logic                       exp_flush,
    output int                         model_errors,
    output int                         table_errors
);

    import cp0_pkg::*;

    localparam logic [31:0] status_mask = 32'h1040_ff17; // CU0 BEV IM UM ERL EXL IE

    logic [31:0] m_status;
    logic        m_bd;
    logic [1:0]  m_ce;
    logic [4:0]  m_exc;
    logic [7:0]  m_ip;
    logic        m_ti;
    logic [31:0] m_epc;
    logic        epc_known; // EPC has been loaded since reset
    logic [31:0] m_badvaddr;
    logic [31:0] m_count;
    logic [31:0] m_compare;
    logic        m_phase; // High on edges where Count steps

    function automatic logic [4:0] expected_exc_code(input exc_type_t kind);
        case (kind)
            exc_int:  return 5'd0;
            exc_adel: return 5'd4;
            exc_ades: return 5'd5;
            exc_sys:  return 5'd8;
            exc_bp:   return 5'd9;
            exc_ri:   return 5'd10;
            exc_cpu:  return 5'd11;
            exc_ov:   return 5'd12;
            exc_trap: return 5'd13;
            default:  return 5'd31;
        endcase
    endfunction

    function automatic logic [31:0] model_read(input cp0_addr_t addr);
        case (addr)
            addr_badvaddr: return m_badvaddr;
            addr_count:    return m_count;
            addr_compare:  return m_compare;
            addr_status:   return m_status;
            addr_cause:    return {m_bd, m_ti, m_ce, 12'b0, m_ip, 1'b0, m_exc, 2'b0};
            addr_epc:      return m_epc;
            default:       return '0;
        endcase
    endfunction

    task automatic compare_signal(input string name, input logic [31:0] exp_val,
                                  input logic [31:0] act_val);
        if (act_val !== exp_val) begin
            model_errors++;
            $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp_val, act_val);
        end
    endtask

    // Model state after each edge from the inputs held at that edge
    always @(posedge clk) begin : model_update
        cp0_addr_t addr;
        logic      wr;
        logic      er;
        addr = {m1s_rd, m1s_sel};
        wr   = m1s_valid && m1s_inst_mtc0 && !m1s_ex;
        er   = m1s_valid && m1s_inst_eret && !m1s_ex;
        if (reset) begin
            m_status  = 32'h0040_0000; // BEV only
            m_bd      = 1'b0;
            m_ce      = 2'b00;
            m_exc     = 5'd31;
            m_ip      = '0;
            m_ti      = 1'b0;
            m_count   = '0;
            m_compare = compare_reset;
            m_phase   = 1'b0;
            epc_known = 1'b0;
        end else begin
            m_ip[7:2] = {ext_int[5] | m_ti, ext_int[4:0]}; // Old TI
            if (wr && addr == addr_cause)
                m_ip[1:0] = m1s_alu_result[9:8];
            if (wr && addr == addr_compare)
                m_ti = 1'b0;
            else if (m_count == m_compare)
                m_ti = 1'b1;
            if (wr && addr == addr_count)
                m_count = m1s_alu_result;
            else if (m_phase)
                m_count = m_count + 32'd1;
            m_phase = !m_phase;
            if (wr && addr == addr_compare)
                m_compare = m1s_alu_result;
            if (wr && addr == addr_epc) begin
                m_epc     = m1s_alu_result;
                epc_known = 1'b1;
            end
            if (m1s_ex) begin
                if (!m_status[1]) begin
                    m_bd      = m1s_bd;
                    m_epc     = m1s_bd ? m1s_pc - 32'd4 : m1s_pc;
                    epc_known = 1'b1;
                end
                m_exc = expected_exc_code(exc_type);
                if (exc_type == exc_cpu)
                    m_ce = 2'b01;
                if (exc_type == exc_ades)
                    m_badvaddr = m1s_alu_result;
                else if (exc_type == exc_adel)
                    m_badvaddr = (m1s_pc[1:0] != 2'b00) ? m1s_pc : m1s_alu_result;
            end
            if (wr && addr == addr_status)
                m_status = m1s_alu_result & status_mask;
            if (m1s_ex)
                m_status[1] = 1'b1;
            else if (er)
                m_status[1] = 1'b0;
        end
    end

    // Outputs are settled half a period after the edge
    always @(negedge clk) begin
        if (!reset) begin
            compare_signal("status_exl", 32'(m_status[1]), 32'(status_exl));
            compare_signal("status_ie", 32'(m_status[0]), 32'(status_ie));
            compare_signal("status_im", 32'(m_status[15:8]), 32'(status_im));
            compare_signal("cause_ti", 32'(m_ti), 32'(cause_ti));
            compare_signal("cause_ip", 32'(m_ip), 32'(cause_ip));
            compare_signal("eret_flush", 32'(exp_flush), 32'(eret_flush));
            if (epc_known)
                compare_signal("epc_out", m_epc, epc_out);
            if (read_check) begin
                compare_signal("cp0_data", model_read({m1s_rd, m1s_sel}), cp0_data);
                if (exp_valid && cp0_data !== exp_data) begin
                    table_errors++;
                    $display("ERROR at %0t ns: cp0_data expected %h (table), got %h",
                             $time, exp_data, cp0_data);
                end
            end
        end
    end

endmodule

// File: cp0.sv
`timescale 1ns/100ps

module cp0 #(
    parameter logic [cp0_pkg::data_w-1:0] compare_reset = 32'h0001_55cc
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       m1s_valid,
    input  logic                       m1s_inst_mtc0,
    input  logic                       m1s_inst_eret,
    input  logic                       m1s_bd,
    input  logic                       m1s_ex,
    input  logic [4:0]                 m1s_rd,
    input  logic [2:0]                 m1s_sel,
    input  logic [cp0_pkg::data_w-1:0] m1s_alu_result,
    input  logic [cp0_pkg::data_w-1:0] m1s_pc,
    input  cp0_pkg::exc_type_t         exc_type,
    input  logic [5:0]                 ext_int,
    output logic [cp0_pkg::data_w-1:0] cp0_data,
    output logic                       eret_flush,
    output logic [cp0_pkg::data_w-1:0] epc_out,
    output logic                       status_ie,
    output logic                       status_exl,
    output logic [7:0]                 status_im,
    output logic [7:0]                 cause_ip,
    output logic                       cause_ti
);

    import cp0_pkg::*;

    logic              status_we;
    logic              cause_we;
    logic              epc_we;
    logic              count_we;
    logic              compare_we;
    logic [data_w-1:0] status_word;
    logic [data_w-1:0] cause_word;
    logic [data_w-1:0] badvaddr;
    logic [data_w-1:0] count;
    logic [data_w-1:0] compare;

    cp0_access i_access (
        .m1s_valid, .m1s_inst_mtc0, .m1s_inst_eret, .m1s_ex, .m1s_rd, .m1s_sel,
        .status_word, .cause_word, .epc(epc_out), .badvaddr, .count, .compare,
        .status_we, .cause_we, .epc_we, .count_we, .compare_we,
        .eret_flush, .cp0_data
    );

    cp0_status i_status (
        .clk, .reset, .status_we, .m1s_ex, .eret_flush, .m1s_alu_result,
        .status_word, .status_exl, .status_ie, .status_im
    );

    cp0_exception_regs i_exception_regs (
        .clk, .reset, .status_exl, .m1s_ex, .m1s_bd, .m1s_pc, .m1s_alu_result,
        .exc_type, .cause_we, .epc_we, .ext_int,
        .timer_int(cause_ti), // TI also feeds IP7
        .cause_word, .epc(epc_out), .badvaddr, .cause_ip
    );

    cp0_timer #(
        .compare_reset(compare_reset)
    ) i_timer (
        .clk, .reset, .count_we, .compare_we, .m1s_alu_result,
        .count, .compare, .timer_int(cause_ti)
    );

endmodule

// File: cp0_timer.sv
`timescale 1ns/100ps

module cp0_timer #(
    parameter logic [cp0_pkg::data_w-1:0] compare_reset = 32'h0001_55cc
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       count_we,
    input  logic                       compare_we,
    input  logic [cp0_pkg::data_w-1:0] m1s_alu_result,
    output logic [cp0_pkg::data_w-1:0] count,
    output logic [cp0_pkg::data_w-1:0] compare,
    output logic                       timer_int
);

    import cp0_pkg::*;

    logic phase; // Half-rate enable for Count

    // Phase keeps toggling even across a Count write
    always_ff @(posedge clk) begin
        if (reset)
            phase <= 1'b0;
        else
            phase <= ~phase;
    end

    always_ff @(posedge clk) begin
        if (reset)
            count <= '0;
        else if (count_we)
            count <= m1s_alu_result;
        else if (phase)
            count <= count + 1'b1;
    end

    always_ff @(posedge clk) begin
        if (reset)
            compare <= compare_reset;
        else if (compare_we)
            compare <= m1s_alu_result;
    end

    // Compare write acknowledges the interrupt
    always_ff @(posedge clk) begin
        if (reset)
            timer_int <= 1'b0;
        else if (compare_we)
            timer_int <= 1'b0;
        else if (count == compare)
            timer_int <= 1'b1;
    end

endmodule

// File: cp0_exception_regs.sv
`timescale 1ns/100ps

module cp0_exception_regs (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       status_exl,
    input  logic                       m1s_ex,
    input  logic                       m1s_bd,
    input  logic [cp0_pkg::data_w-1:0] m1s_pc,
    input  logic [cp0_pkg::data_w-1:0] m1s_alu_result,
    input  cp0_pkg::exc_type_t         exc_type,
    input  logic                       cause_we,
    input  logic                       epc_we,
    input  logic [5:0]                 ext_int,
    input  logic                       timer_int,
    output logic [cp0_pkg::data_w-1:0] cause_word,
    output logic [cp0_pkg::data_w-1:0] epc,
    output logic [cp0_pkg::data_w-1:0] badvaddr,
    output logic [7:0]                 cause_ip
);

    import cp0_pkg::*;

    logic       cause_bd;
    logic [1:0] cause_ce;
    logic [4:0] cause_exc;
    logic       first_ex; // Exception taken from normal level

    assign first_ex = m1s_ex && !status_exl;

    // BD only follows the first exception of a nest
    always_ff @(posedge clk) begin
        if (reset)
            cause_bd <= 1'b0;
        else if (first_ex)
            cause_bd <= m1s_bd;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cause_exc <= exc_code_none;
            cause_ce  <= 2'b00;
        end else if (m1s_ex) begin
            cause_exc <= exc_code(exc_type);
            if (exc_type == exc_cpu)
                cause_ce <= 2'b01; // Only CP1 users trap here
        end
    end

    // Hardware lines sampled every cycle, timer shares IP7
    always_ff @(posedge clk) begin
        if (reset)
            cause_ip[7:2] <= '0;
        else
            cause_ip[7:2] <= {ext_int[5] | timer_int, ext_int[4:0]};
    end

    always_ff @(posedge clk) begin
        if (reset)
            cause_ip[1:0] <= '0;
        else if (cause_we)
            cause_ip[1:0] <= m1s_alu_result[cause_ip_lsb+1:cause_ip_lsb]; // Software interrupts
    end

    always_ff @(posedge clk) begin
        if (first_ex)
            epc <= m1s_bd ? m1s_pc - 32'd4 : m1s_pc; // Delay slot points at the branch
        else if (epc_we)
            epc <= m1s_alu_result;
    end

    always_ff @(posedge clk) begin
        if (m1s_ex) begin
            if (exc_type == exc_ades)
                badvaddr <= m1s_alu_result;
            else if (exc_type == exc_adel)
                badvaddr <= (|m1s_pc[1:0]) ? m1s_pc : m1s_alu_result; // Fetch or load fault
        end
    end

    always_comb begin
        cause_word                              = '0;
        cause_word[cause_bd_pos]                = cause_bd;
        cause_word[cause_ti_pos]                = timer_int;
        cause_word[cause_ce_msb:cause_ce_lsb]   = cause_ce;
        cause_word[cause_ip_msb:cause_ip_lsb]   = cause_ip;
        cause_word[cause_exc_msb:cause_exc_lsb] = cause_exc;
    end

endmodule

// File: cp0_status.sv
`timescale 1ns/100ps

module cp0_status (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       status_we,
    input  logic                       m1s_ex,
    input  logic                       eret_flush,
    input  logic [cp0_pkg::data_w-1:0] m1s_alu_result,
    output logic [cp0_pkg::data_w-1:0] status_word,
    output logic                       status_exl,
    output logic                       status_ie,
    output logic [7:0]                 status_im
);

    import cp0_pkg::*;

    logic cu0;
    logic bev;
    logic um;
    logic erl;

    // Plain read/write fields
    always_ff @(posedge clk) begin
        if (reset) begin
            cu0       <= 1'b0;
            bev       <= 1'b1; // Boot vectors after reset
            status_im <= '0;
            um        <= 1'b0;
            erl       <= 1'b0;
            status_ie <= 1'b0;
        end else if (status_we) begin
            cu0       <= m1s_alu_result[status_cu0_pos];
            bev       <= m1s_alu_result[status_bev_pos];
            status_im <= m1s_alu_result[status_im_msb:status_im_lsb];
            um        <= m1s_alu_result[status_um_pos];
            erl       <= m1s_alu_result[status_erl_pos];
            status_ie <= m1s_alu_result[status_ie_pos];
        end
    end

    // Exception beats eret, eret beats mtc0
    always_ff @(posedge clk) begin
        if (reset)
            status_exl <= 1'b0;
        else if (m1s_ex)
            status_exl <= 1'b1;
        else if (eret_flush)
            status_exl <= 1'b0;
        else if (status_we)
            status_exl <= m1s_alu_result[status_exl_pos];
    end

    always_comb begin
        status_word                              = '0; // Unimplemented bits read 0
        status_word[status_cu0_pos]              = cu0;
        status_word[status_bev_pos]              = bev;
        status_word[status_im_msb:status_im_lsb] = status_im;
        status_word[status_um_pos]               = um;
        status_word[status_erl_pos]              = erl;
        status_word[status_exl_pos]              = status_exl;
        status_word[status_ie_pos]               = status_ie;
    end

endmodule

// File: cp0_access.sv
`timescale 1ns/100ps

module cp0_access (
    input  logic                       m1s_valid,
    input  logic                       m1s_inst_mtc0,
    input  logic                       m1s_inst_eret,
    input  logic                       m1s_ex,
    input  logic [4:0]                 m1s_rd,
    input  logic [2:0]                 m1s_sel,
    input  logic [cp0_pkg::data_w-1:0] status_word,
    input  logic [cp0_pkg::data_w-1:0] cause_word,
    input  logic [cp0_pkg::data_w-1:0] epc,
    input  logic [cp0_pkg::data_w-1:0] badvaddr,
    input  logic [cp0_pkg::data_w-1:0] count,
    input  logic [cp0_pkg::data_w-1:0] compare,
    output logic                       status_we,
    output logic                       cause_we,
    output logic                       epc_we,
    output logic                       count_we,
    output logic                       compare_we,
    output logic                       eret_flush,
    output logic [cp0_pkg::data_w-1:0] cp0_data
);

    import cp0_pkg::*;

    cp0_addr_t addr;
    logic      mtc0_ok;

    assign addr = {m1s_rd, m1s_sel}; // Same address for mtc0 and mfc0

    // A faulting instruction must not touch CP0
    assign mtc0_ok    = m1s_valid && m1s_inst_mtc0 && !m1s_ex;
    assign eret_flush = m1s_valid && m1s_inst_eret && !m1s_ex;

    always_comb begin
        status_we  = 1'b0;
        cause_we   = 1'b0;
        epc_we     = 1'b0;
        count_we   = 1'b0;
        compare_we = 1'b0;
        if (mtc0_ok) begin
            case (addr)
                addr_status:  status_we  = 1'b1;
                addr_cause:   cause_we   = 1'b1;
                addr_epc:     epc_we     = 1'b1;
                addr_count:   count_we   = 1'b1;
                addr_compare: compare_we = 1'b1;
                default:      ; // BadVAddr is read only
            endcase
        end
    end

    // mfc0 read path, purely combinational
    always_comb begin
        case (addr)
            addr_badvaddr: cp0_data = badvaddr;
            addr_count:    cp0_data = count;
            addr_compare:  cp0_data = compare;
            addr_status:   cp0_data = status_word;
            addr_cause:    cp0_data = cause_word;
            addr_epc:      cp0_data = epc;
            default:       cp0_data = '0; // Unmapped
        endcase
    end

endmodule

// File: cp0_pkg.sv
package cp0_pkg;

    localparam int data_w = 32; // CP0 word, ALU result and PC

    typedef logic [7:0] cp0_addr_t; // {rd, sel}

    // Implemented register addresses as {rd, sel}
    localparam cp0_addr_t addr_badvaddr = {5'd8, 3'd0};
    localparam cp0_addr_t addr_count    = {5'd9, 3'd0};
    localparam cp0_addr_t addr_compare  = {5'd11, 3'd0};
    localparam cp0_addr_t addr_status   = {5'd12, 3'd0};
    localparam cp0_addr_t addr_cause    = {5'd13, 3'd0};
    localparam cp0_addr_t addr_epc      = {5'd14, 3'd0};

    localparam int status_ie_pos  = 0;
    localparam int status_exl_pos = 1;
    localparam int status_erl_pos = 2;
    localparam int status_um_pos  = 4;
    localparam int status_im_lsb  = 8;
    localparam int status_im_msb  = 15;
    localparam int status_bev_pos = 22;
    localparam int status_cu0_pos = 28;

    localparam int cause_exc_lsb = 2;
    localparam int cause_exc_msb = 6;
    localparam int cause_ip_lsb  = 8;
    localparam int cause_ip_msb  = 15;
    localparam int cause_ce_lsb  = 28;
    localparam int cause_ce_msb  = 29;
    localparam int cause_ti_pos  = 30;
    localparam int cause_bd_pos  = 31;

    localparam logic [4:0] exc_code_none = 5'd31; // No exception recorded

    // Exception kinds as raised inside the pipeline
    typedef enum logic [4:0] {
        exc_none,
        exc_int,
        exc_adel,
        exc_ades,
        exc_sys,
        exc_bp,
        exc_ri,
        exc_cpu,
        exc_ov,
        exc_trap
    } exc_type_t;

    // Architectural ExcCode for Cause[6:2]
    function automatic logic [4:0] exc_code(input exc_type_t kind);
        logic [4:0] code;
        case (kind)
            exc_int:  code = 5'd0;
            exc_adel: code = 5'd4;
            exc_ades: code = 5'd5;
            exc_sys:  code = 5'd8;
            exc_bp:   code = 5'd9;
            exc_ri:   code = 5'd10;
            exc_cpu:  code = 5'd11;
            exc_ov:   code = 5'd12;
            exc_trap: code = 5'd13;
            default:  code = exc_code_none; // Includes exc_none
        endcase
        return code;
    endfunction

endpackage
